// ==== common/fwd_pkg.sv ====
`default_nettype none

package fwd_pkg;

   // Stages that can supply a pending result
   localparam int NUM_FWD_STAGES = 3;

   // One match bit per forwarding stage for a single operand
   typedef logic [NUM_FWD_STAGES-1:0] raw_vec_t;

   // Positions in raw_vec_t
   // Higher bit means newer result and higher priority
   localparam int RAW_EXU   = 2;  // Instruction N-1
   localparam int RAW_MACCU = 1;  // Instruction N-2
   localparam int RAW_WBU   = 0;  // Instruction N-3

endpackage

`default_nettype wire

// ==== common/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

   // Register file address, x0 to x31
   typedef logic [4:0] reg_addr_t;

   // One-hot instruction class, R I S B U J from MSB down
   typedef logic [5:0] instr_type_t;

   // Bit positions inside instr_type_t
   localparam int TYPE_R = 5;  // Register-register ALU ops
   localparam int TYPE_I = 4;  // Immediate ALU ops and loads
   localparam int TYPE_S = 3;  // Stores
   localparam int TYPE_B = 2;  // Branches
   localparam int TYPE_U = 1;  // LUI and AUIPC
   localparam int TYPE_J = 0;  // JAL

   // Hardwired zero register
   localparam reg_addr_t REG_X0 = 5'd0;

endpackage

`default_nettype wire

// ==== design/operand_select.sv ====
`timescale 1ns/1ps
`default_nettype none

// Priority mux picking the newest pending result per operand
module operand_select
   import fwd_pkg::*;
#(
   parameter int XLEN = 32  // Data width
) (
   input  logic [XLEN-1:0] i_rf_op0,        // Operand 0 from register file
   input  logic [XLEN-1:0] i_rf_op1,        // Operand 1 from register file
   input  logic [XLEN-1:0] i_exu_result,    // Result at EXU
   input  logic [XLEN-1:0] i_maccu_result,  // Result at MACCU
   input  logic [XLEN-1:0] i_wbu_result,    // Result at WBU
   input  raw_vec_t        i_op0_raw,       // Operand 0 matches per stage
   input  raw_vec_t        i_op1_raw,       // Operand 1 matches per stage
   output logic [XLEN-1:0] o_fwd_op0,       // Forwarded operand 0
   output logic [XLEN-1:0] o_fwd_op1        // Forwarded operand 1
);

   // Select for a single operand
   // EXU over MACCU over WBU over register file
   function automatic logic [XLEN-1:0] pick_operand(
      input raw_vec_t        raw,
      input logic [XLEN-1:0] rf_val
   );
      logic [XLEN-1:0] sel;
      if (raw[RAW_EXU]) begin
         sel = i_exu_result;    // Newest producer
      end else if (raw[RAW_MACCU]) begin
         sel = i_maccu_result;
      end else if (raw[RAW_WBU]) begin
         sel = i_wbu_result;    // Oldest pending producer
      end else begin
         sel = rf_val;          // No hazard, bypass
      end
      return sel;
   endfunction

   // Operands are resolved independently
   always_comb begin
      o_fwd_op0 = pick_operand(i_op0_raw, i_rf_op0);
      o_fwd_op1 = pick_operand(i_op1_raw, i_rf_op1);
   end

endmodule

`default_nettype wire

// ==== design/opfwd_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// Operand forwarding control for the decode to execute boundary
module opfwd_control
   import rv_isa_pkg::*;
   import fwd_pkg::*;
#(
   parameter int XLEN = 32  // Data width
) (
   // Register file operands
   input  logic [XLEN-1:0] i_rf_op0,
   input  logic [XLEN-1:0] i_rf_op1,

   // Decode unit
   input  reg_addr_t       i_du_rs0,
   input  reg_addr_t       i_du_rs1,
   input  instr_type_t     i_du_instr_type,
   input  logic            i_du_instr_valid,

   // Execute unit, instruction N-1
   input  logic [XLEN-1:0] i_exu_result,
   input  reg_addr_t       i_exu_rdt,
   input  instr_type_t     i_exu_instr_type,
   input  logic            i_exu_instr_valid,

   // Memory access unit, instruction N-2
   input  logic [XLEN-1:0] i_maccu_result,
   input  reg_addr_t       i_maccu_rdt,
   input  instr_type_t     i_maccu_instr_type,
   input  logic            i_maccu_instr_valid,

   // Write back unit, instruction N-3
   input  logic [XLEN-1:0] i_wbu_result,
   input  reg_addr_t       i_wbu_rdt,
   input  instr_type_t     i_wbu_instr_type,
   input  logic            i_wbu_instr_valid,

   // Operands towards EXU
   output logic [XLEN-1:0] o_fwd_op0,
   output logic [XLEN-1:0] o_fwd_op1
);

   logic     exu_op0_raw,   exu_op1_raw;    // Match flags from EXU detector
   logic     maccu_op0_raw, maccu_op1_raw;  // Match flags from MACCU detector
   logic     wbu_op0_raw,   wbu_op1_raw;    // Match flags from WBU detector
   raw_vec_t op0_raw;                       // Operand 0 match vector
   raw_vec_t op1_raw;                       // Operand 1 match vector

   stage_hazard_detect u_exu_hzd (
      .i_du_rs0            (i_du_rs0),
      .i_du_rs1            (i_du_rs1),
      .i_du_instr_type     (i_du_instr_type),
      .i_du_instr_valid    (i_du_instr_valid),
      .i_stage_rdt         (i_exu_rdt),
      .i_stage_instr_type  (i_exu_instr_type),
      .i_stage_instr_valid (i_exu_instr_valid),
      .o_op0_raw           (exu_op0_raw),
      .o_op1_raw           (exu_op1_raw)
   );

   stage_hazard_detect u_maccu_hzd (
      .i_du_rs0            (i_du_rs0),
      .i_du_rs1            (i_du_rs1),
      .i_du_instr_type     (i_du_instr_type),
      .i_du_instr_valid    (i_du_instr_valid),
      .i_stage_rdt         (i_maccu_rdt),
      .i_stage_instr_type  (i_maccu_instr_type),
      .i_stage_instr_valid (i_maccu_instr_valid),
      .o_op0_raw           (maccu_op0_raw),
      .o_op1_raw           (maccu_op1_raw)
   );

   stage_hazard_detect u_wbu_hzd (
      .i_du_rs0            (i_du_rs0),
      .i_du_rs1            (i_du_rs1),
      .i_du_instr_type     (i_du_instr_type),
      .i_du_instr_valid    (i_du_instr_valid),
      .i_stage_rdt         (i_wbu_rdt),
      .i_stage_instr_type  (i_wbu_instr_type),
      .i_stage_instr_valid (i_wbu_instr_valid),
      .o_op0_raw           (wbu_op0_raw),
      .o_op1_raw           (wbu_op1_raw)
   );

   // Pack flags by stage priority
   assign op0_raw[RAW_EXU]   = exu_op0_raw;
   assign op0_raw[RAW_MACCU] = maccu_op0_raw;
   assign op0_raw[RAW_WBU]   = wbu_op0_raw;

   assign op1_raw[RAW_EXU]   = exu_op1_raw;
   assign op1_raw[RAW_MACCU] = maccu_op1_raw;
   assign op1_raw[RAW_WBU]   = wbu_op1_raw;

   operand_select #(
      .XLEN (XLEN)
   ) u_operand_select (
      .i_rf_op0       (i_rf_op0),
      .i_rf_op1       (i_rf_op1),
      .i_exu_result   (i_exu_result),
      .i_maccu_result (i_maccu_result),
      .i_wbu_result   (i_wbu_result),
      .i_op0_raw      (op0_raw),
      .i_op1_raw      (op1_raw),
      .o_fwd_op0      (o_fwd_op0),
      .o_fwd_op1      (o_fwd_op1)
   );

endmodule

`default_nettype wire

// ==== design/stage_hazard_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

// RAW test of the decode instruction against one downstream stage
module stage_hazard_detect
   import rv_isa_pkg::*;
(
   // Decode side, the consumer
   input  reg_addr_t   i_du_rs0,             // Source register of operand 0
   input  reg_addr_t   i_du_rs1,             // Source register of operand 1
   input  instr_type_t i_du_instr_type,      // Class of decode instruction
   input  logic        i_du_instr_valid,     // Decode instruction valid

   // Stage side, the producer
   input  reg_addr_t   i_stage_rdt,          // Destination register at stage
   input  instr_type_t i_stage_instr_type,   // Class of stage instruction
   input  logic        i_stage_instr_valid,  // Stage instruction valid

   // Match flags
   output logic        o_op0_raw,            // Operand 0 depends on stage result
   output logic        o_op1_raw             // Operand 1 depends on stage result
);

   logic du_reads_regs;     // Decode instruction reads rs0/rs1
   logic stage_writes_rd;   // Stage instruction writes rd
   logic rdt_not_x0;        // Destination is a real register
   logic hazard_window;     // All gating conditions met
   logic rs0_match;
   logic rs1_match;

   // Only R/I/S/B classes consume register operands
   assign du_reads_regs = i_du_instr_type[TYPE_R]
                        | i_du_instr_type[TYPE_I]
                        | i_du_instr_type[TYPE_S]
                        | i_du_instr_type[TYPE_B];

   // Only R/I/U/J classes produce a register result
   // S and B never write back
   assign stage_writes_rd = i_stage_instr_type[TYPE_R]
                          | i_stage_instr_type[TYPE_I]
                          | i_stage_instr_type[TYPE_U]
                          | i_stage_instr_type[TYPE_J];

   // Writes to x0 are discarded so they never forward
   assign rdt_not_x0 = (i_stage_rdt != REG_X0);

   assign hazard_window = du_reads_regs
                        & stage_writes_rd
                        & i_du_instr_valid
                        & i_stage_instr_valid
                        & rdt_not_x0;

   // Address compares
   assign rs0_match = (i_du_rs0 == i_stage_rdt);
   assign rs1_match = (i_du_rs1 == i_stage_rdt);  // Also raised for I-type, rs1 unused there

   assign o_op0_raw = hazard_window & rs0_match;
   assign o_op1_raw = hazard_window & rs1_match;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench and RTL with Verilator, then run the simulation
# A $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -j 0 \
   -f vlog.f --top-module tb_opfwd_control \
   --Mdir obj_dir -o sim_opfwd_control &&
./obj_dir/sim_opfwd_control &&
echo "Simulation completed" ||
{ echo "Simulation failed"; exit 1; }

// ==== verification/opfwd_cases.txt ====
# du_valid du_type rs0 rs1 rf_op0 rf_op1, then valid type rd result for exu maccu wbu
# last two columns are the expected fwd_op0 and fwd_op1, all hex, types one-hot R=20 I=10 S=08 B=04 U=02 J=01
1 20 01 02 a0a0 b1b1  0 20 01 e1e1  0 20 01 c2c2  0 20 02 d3d3  a0a0 b1b1
1 20 01 02 a0a0 b1b1  1 20 03 e1e1  1 10 04 c2c2  1 20 05 d3d3  a0a0 b1b1
1 20 01 02 a0a0 b1b1  1 20 01 e1e1  0 20 00 c2c2  0 20 00 d3d3  e1e1 b1b1
1 20 01 02 a0a0 b1b1  1 20 02 e1e1  0 20 00 c2c2  0 20 00 d3d3  a0a0 e1e1
1 20 01 02 a0a0 b1b1  0 20 00 e1e1  1 20 01 c2c2  0 20 00 d3d3  c2c2 b1b1
1 20 01 02 a0a0 b1b1  0 20 00 e1e1  1 20 02 c2c2  0 20 00 d3d3  a0a0 c2c2
1 20 01 02 a0a0 b1b1  0 20 00 e1e1  0 20 00 c2c2  1 20 01 d3d3  d3d3 b1b1
1 20 01 02 a0a0 b1b1  0 20 00 e1e1  0 20 00 c2c2  1 20 02 d3d3  a0a0 d3d3
1 20 01 02 a0a0 b1b1  1 20 01 e1e1  0 20 00 c2c2  1 20 02 d3d3  e1e1 d3d3
1 20 01 02 a0a0 b1b1  0 20 00 e1e1  1 20 02 c2c2  1 20 01 d3d3  d3d3 c2c2
1 20 05 05 a0a0 b1b1  1 20 05 e1e1  0 20 00 c2c2  0 20 00 d3d3  e1e1 e1e1
1 20 01 02 a0a0 b1b1  1 20 01 e1e1  1 20 01 c2c2  1 20 01 d3d3  e1e1 b1b1
1 20 01 02 a0a0 b1b1  0 20 01 e1e1  1 20 01 c2c2  1 20 01 d3d3  c2c2 b1b1
1 20 01 02 a0a0 b1b1  1 20 02 e1e1  1 20 02 c2c2  1 20 02 d3d3  a0a0 e1e1
1 20 01 02 a0a0 b1b1  0 20 02 e1e1  1 20 02 c2c2  1 20 02 d3d3  a0a0 c2c2
1 20 00 00 a0a0 b1b1  1 20 00 e1e1  0 20 00 c2c2  0 20 00 d3d3  a0a0 b1b1
1 20 00 02 a0a0 b1b1  1 20 00 e1e1  1 20 00 c2c2  1 20 00 d3d3  a0a0 b1b1
1 20 00 03 a0a0 b1b1  1 20 00 e1e1  1 20 03 c2c2  0 20 00 d3d3  a0a0 c2c2
1 02 01 02 a0a0 b1b1  1 20 01 e1e1  1 20 02 c2c2  0 20 00 d3d3  a0a0 b1b1
1 01 01 02 a0a0 b1b1  1 20 01 e1e1  1 20 02 c2c2  0 20 00 d3d3  a0a0 b1b1
1 20 01 02 a0a0 b1b1  1 08 01 e1e1  0 20 00 c2c2  1 08 02 d3d3  a0a0 b1b1
1 20 01 02 a0a0 b1b1  1 04 02 e1e1  1 04 01 c2c2  0 20 00 d3d3  a0a0 b1b1
1 20 01 02 a0a0 b1b1  1 08 01 e1e1  1 20 01 c2c2  0 20 00 d3d3  c2c2 b1b1
0 20 01 02 a0a0 b1b1  1 20 01 e1e1  1 20 02 c2c2  0 20 00 d3d3  a0a0 b1b1
1 10 01 02 a0a0 b1b1  1 20 02 e1e1  0 20 00 c2c2  0 20 00 d3d3  a0a0 e1e1
1 08 01 02 a0a0 b1b1  1 02 01 e1e1  0 20 00 c2c2  1 01 02 d3d3  e1e1 d3d3
1 04 01 02 a0a0 b1b1  0 20 00 e1e1  1 10 01 c2c2  0 20 00 d3d3  c2c2 b1b1
1 20 01 02 a0a0 b1b1  0 20 01 e1e1  1 20 01 c2c2  1 10 02 d3d3  c2c2 d3d3

// ==== verification/tb_opfwd_control.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the operand forwarding control
module tb_opfwd_control
   import rv_isa_pkg::*;
();

   localparam int XLEN         = 32;
   localparam int CLK_PERIOD   = 100;             // ns
   localparam int DRIVE_DLY    = 5;               // Inputs change after rising edge
   localparam int SAMPLE_DLY   = 90;              // Outputs read before next edge
   localparam int EDGE_TIMEOUT = 2 * CLK_PERIOD;  // Polls of 1 ns
   localparam int NUM_FIELDS   = 20;              // Columns per case line
   localparam int NUM_RANDOM   = 200;

   logic            clk;
   logic            reset;  // High for the first two cycles

   // DUT inputs
   logic [XLEN-1:0] rf_op0;
   logic [XLEN-1:0] rf_op1;
   reg_addr_t       du_rs0;
   reg_addr_t       du_rs1;
   instr_type_t     du_instr_type;
   logic            du_instr_valid;
   logic [XLEN-1:0] exu_result;
   reg_addr_t       exu_rdt;
   instr_type_t     exu_instr_type;
   logic            exu_instr_valid;
   logic [XLEN-1:0] maccu_result;
   reg_addr_t       maccu_rdt;
   instr_type_t     maccu_instr_type;
   logic            maccu_instr_valid;
   logic [XLEN-1:0] wbu_result;
   reg_addr_t       wbu_rdt;
   instr_type_t     wbu_instr_type;
   logic            wbu_instr_valid;

   // DUT outputs
   logic [XLEN-1:0] fwd_op0;
   logic [XLEN-1:0] fwd_op1;

   opfwd_control #(
      .XLEN (XLEN)
   ) dut (
      .i_rf_op0            (rf_op0),
      .i_rf_op1            (rf_op1),
      .i_du_rs0            (du_rs0),
      .i_du_rs1            (du_rs1),
      .i_du_instr_type     (du_instr_type),
      .i_du_instr_valid    (du_instr_valid),
      .i_exu_result        (exu_result),
      .i_exu_rdt           (exu_rdt),
      .i_exu_instr_type    (exu_instr_type),
      .i_exu_instr_valid   (exu_instr_valid),
      .i_maccu_result      (maccu_result),
      .i_maccu_rdt         (maccu_rdt),
      .i_maccu_instr_type  (maccu_instr_type),
      .i_maccu_instr_valid (maccu_instr_valid),
      .i_wbu_result        (wbu_result),
      .i_wbu_rdt           (wbu_rdt),
      .i_wbu_instr_type    (wbu_instr_type),
      .i_wbu_instr_valid   (wbu_instr_valid),
      .o_fwd_op0           (fwd_op0),
      .o_fwd_op1           (fwd_op1)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Stop the run with a reason
   task automatic abort_run(input string reason);
      $display("ERROR: %s", reason);
      $display("=== FAIL ===");
      $fatal(1, "Run aborted");
   endtask

   task automatic check_value(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] expected);
      if (got !== expected) begin
         $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, expected);
         abort_run("Output differs from expected value");
      end
   endtask

   // Bounded poll for a low to high clock change
   task automatic wait_clock_rise();
      logic prev_clk;
      int   polls;
      prev_clk = clk;
      polls = 0;
      #1;
      while (!(prev_clk === 1'b0 && clk === 1'b1)) begin
         if (polls >= EDGE_TIMEOUT) begin
            abort_run("Clock did not rise within the timeout");
         end
         prev_clk = clk;
         polls++;
         #1;
      end
   endtask

   task automatic drive_idle();
      rf_op0 = '0;
      rf_op1 = '0;
      du_rs0 = '0;
      du_rs1 = '0;
      du_instr_type = '0;
      du_instr_valid = 1'b0;
      exu_result = '0;
      exu_rdt = '0;
      exu_instr_type = '0;
      exu_instr_valid = 1'b0;
      maccu_result = '0;
      maccu_rdt = '0;
      maccu_instr_type = '0;
      maccu_instr_valid = 1'b0;
      wbu_result = '0;
      wbu_rdt = '0;
      wbu_instr_type = '0;
      wbu_instr_valid = 1'b0;
   endtask

   // Comment and blank lines carry no case
   function automatic bit is_skip_line(input string line);
      return (line.len() == 0) || (line.getc(0) == "#") || (line.getc(0) == "\n");
   endfunction

   task automatic run_case_file();
      int          fd;
      int          n_read;
      int          n_fields;
      int          line_no;
      int          n_cases;
      string       line;
      logic [31:0] f [NUM_FIELDS];  // Columns of one case
      line_no = 0;
      n_cases = 0;
      fd = $fopen("verification/opfwd_cases.txt", "r");
      if (fd == 0) begin
         abort_run("Cannot open case file verification/opfwd_cases.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n_read = $fgets(line, fd);
            line_no++;
            if (n_read > 0 && !is_skip_line(line)) begin
               n_fields = $sscanf(line,
                  "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
               if (n_fields != NUM_FIELDS) begin
                  abort_run($sformatf("Malformed line %0d in case file", line_no));
               end
               wait_clock_rise();
               #DRIVE_DLY;
               du_instr_valid    = f[0][0];
               du_instr_type     = f[1][5:0];
               du_rs0            = f[2][4:0];
               du_rs1            = f[3][4:0];
               rf_op0            = f[4];
               rf_op1            = f[5];
               exu_instr_valid   = f[6][0];
               exu_instr_type    = f[7][5:0];
               exu_rdt           = f[8][4:0];
               exu_result        = f[9];
               maccu_instr_valid = f[10][0];
               maccu_instr_type  = f[11][5:0];
               maccu_rdt         = f[12][4:0];
               maccu_result      = f[13];
               wbu_instr_valid   = f[14][0];
               wbu_instr_type    = f[15][5:0];
               wbu_rdt           = f[16][4:0];
               wbu_result        = f[17];
               #SAMPLE_DLY;  // Outputs settled before the next edge
               check_value($sformatf("line %0d operand 0", line_no), fwd_op0, f[18]);
               check_value($sformatf("line %0d operand 1", line_no), fwd_op1, f[19]);
               n_cases++;
            end
         end
         $fclose(fd);
         if (n_cases == 0) begin
            abort_run("Case file holds no cases");
         end
      end
   endtask

   // No stage valid, so both operands come from the register file
   task automatic run_random_bypass();
      int i;
      for (i = 0; i < NUM_RANDOM; i++) begin
         wait_clock_rise();
         #DRIVE_DLY;
         rf_op0            = $urandom();
         rf_op1            = $urandom();
         du_rs0            = reg_addr_t'($urandom());
         du_rs1            = reg_addr_t'($urandom());
         du_instr_type     = instr_type_t'($urandom());
         du_instr_valid    = 1'($urandom());
         exu_result        = $urandom();
         exu_rdt           = reg_addr_t'($urandom());
         exu_instr_type    = instr_type_t'($urandom());
         exu_instr_valid   = 1'b0;
         maccu_result      = $urandom();
         maccu_rdt         = reg_addr_t'($urandom());
         maccu_instr_type  = instr_type_t'($urandom());
         maccu_instr_valid = 1'b0;
         wbu_result        = $urandom();
         wbu_rdt           = reg_addr_t'($urandom());
         wbu_instr_type    = instr_type_t'($urandom());
         wbu_instr_valid   = 1'b0;
         #SAMPLE_DLY;
         check_value($sformatf("random %0d operand 0", i), fwd_op0, rf_op0);
         check_value($sformatf("random %0d operand 1", i), fwd_op1, rf_op1);
      end
   endtask

   initial begin
      void'($urandom(16624));
      drive_idle();
      reset = 1'b1;
      repeat (2) wait_clock_rise();
      #DRIVE_DLY reset = 1'b0;
      run_case_file();      // Directed cases
      run_random_bypass();
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/rv_isa_pkg.sv
common/fwd_pkg.sv
design/stage_hazard_detect.sv
design/operand_select.sv
design/opfwd_control.sv
verification/tb_opfwd_control.sv
